// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the wiscCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module wiscCore_tb -f wiscCore.f -o wiscSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/wiscSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== source/aluExecute.sv ====
////////////////////////////////////////
// WISC ALU and condition logic
////////////////////////////////////////
`timescale 1ns/1ps

module aluExecute (
   input  wiscPkg::ctrlT                 ctrl,
   input  wiscPkg::instrT                instr,
   input  logic [wiscPkg::dataWidth-1:0] rsData,
   input  logic [wiscPkg::dataWidth-1:0] rtData,
   output logic [wiscPkg::dataWidth-1:0] aluOut,
   output logic                          condTrue
);
   import wiscPkg::*;

   logic [dataWidth-1:0]   imm5Ext, imm8Ext;
   logic [dataWidth-1:0]   opB, a, b;
   logic [dataWidth:0]     sum;                   // extra bit holds carry out
   logic [2*dataWidth-1:0] rolWide, rorWide;
   logic [dataWidth-1:0]   rev;
   logic [3:0]             shAmt;
   logic                   zeroFlag, signFlag, carryFlag, ovf;

   assign imm5Ext = ctrl.zeroExt ? {{(dataWidth-5){1'b0}}, instr.iForm.imm5}
                                 : {{(dataWidth-5){instr.iForm.imm5[4]}}, instr.iForm.imm5};
   assign imm8Ext = ctrl.zeroExt ? {{(dataWidth-8){1'b0}}, instr.i2Form.imm8}
                                 : {{(dataWidth-8){instr.i2Form.imm8[7]}}, instr.i2Form.imm8};

   always_comb begin
      case (ctrl.bSrc)
         bReg:    opB = rtData;
         bImm5:   opB = imm5Ext;
         bImm8:   opB = imm8Ext;
         default: opB = '0;                      // branches compare rs with zero
      endcase
   end

   assign a     = ctrl.invA ? ~rsData : rsData;
   assign b     = ctrl.invB ? ~opB : opB;
   assign sum   = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, ctrl.cin};
   assign shAmt = b[3:0];                        // low 4 bits only
   assign rolWide = {a, a} << shAmt;             // upper half is the rotate
   assign rorWide = {a, a} >> shAmt;             // lower half is the rotate

   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         rev[i] = rsData[dataWidth-1-i];
      end
   end

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  aluOut = sum[dataWidth-1:0];
         aluXor:  aluOut = a ^ b;
         aluAndn: aluOut = a & ~b;
         aluRol:  aluOut = rolWide[2*dataWidth-1:dataWidth];
         aluSll:  aluOut = a << shAmt;
         aluRor:  aluOut = rorWide[dataWidth-1:0];
         aluSrl:  aluOut = a >> shAmt;
         default: aluOut = rev;                  // btr
      endcase
   end

   // flags always come from the adder
   assign zeroFlag  = (sum[dataWidth-1:0] == '0);
   assign carryFlag = sum[dataWidth];
   assign ovf       = (a[dataWidth-1] == b[dataWidth-1]) && (sum[dataWidth-1] != a[dataWidth-1]);
   assign signFlag  = sum[dataWidth-1] ^ ovf;    // true signed less than

   always_comb begin
      case (ctrl.condSel)
         condZero:       condTrue = zeroFlag;
         condNotZero:    condTrue = !zeroFlag;
         condSign:       condTrue = signFlag;
         condNotSign:    condTrue = !signFlag;
         condSignOrZero: condTrue = signFlag || zeroFlag;
         condCarry:      condTrue = carryFlag;
         default:        condTrue = 1'b0;
      endcase
   end

endmodule

// ==== source/controlUnit.sv ====
////////////////////////////////////////
// WISC opcode decoder
////////////////////////////////////////
`timescale 1ns/1ps

module controlUnit (
   input  wiscPkg::instrT instr,
   output wiscPkg::ctrlT  ctrl
);
   import wiscPkg::*;

   always_comb begin
      ctrl = '0;                                 // defaults everywhere so nothing latches
      ctrl.aluOp   = aluAdd;
      ctrl.bSrc    = bReg;
      ctrl.condSel = condNone;
      ctrl.wbSel   = wbAlu;
      ctrl.dstSel  = dstIRd;
      case (instr.iForm.opcode)
         opHalt: begin
            ctrl.halt = 1'b1;
         end
         opNop, opSiic, opRti: begin
            // no exceptions here, behaves as nop
         end
         opAddi: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = bImm5;                 // sign extended imm5
         end
         opSubi: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = bImm5;
            ctrl.invA   = 1'b1;                  // imm minus rs
            ctrl.cin    = 1'b1;
         end
         opXori, opAndni: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = bImm5;
            ctrl.zeroExt = 1'b1;
            ctrl.aluOp   = (instr.iForm.opcode == opXori) ? aluXor : aluAndn;
         end
         opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = bImm5;
            ctrl.zeroExt = 1'b1;                 // shift amount is unsigned
            case (instr.iForm.opcode)
               opRoli:  ctrl.aluOp = aluRol;
               opSlli:  ctrl.aluOp = aluSll;
               opRori:  ctrl.aluOp = aluRor;
               default: ctrl.aluOp = aluSrl;
            endcase
         end
         opSt, opLd, opStu: begin
            ctrl.bSrc   = bImm5;                 // address still formed
            ctrl.regWrt = 1'b0;                  // no data memory
            ctrl.err    = 1'b1;
         end
         opBtr: begin
            ctrl.regWrt = 1'b1;
            ctrl.aluOp  = aluBtr;
            ctrl.dstSel = dstRRd;
         end
         opAluR: begin
            ctrl.regWrt = 1'b1;
            ctrl.dstSel = dstRRd;
            case (instr.rForm.func)
               2'b00: ctrl.aluOp = aluAdd;
               2'b01: begin                      // sub is rt minus rs
                  ctrl.aluOp = aluAdd;
                  ctrl.invA  = 1'b1;
                  ctrl.cin   = 1'b1;
               end
               2'b10: ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAndn;
            endcase
         end
         opShiftR: begin
            ctrl.regWrt = 1'b1;
            ctrl.dstSel = dstRRd;
            case (instr.rForm.func)
               2'b00: ctrl.aluOp = aluRol;
               2'b01: ctrl.aluOp = aluSll;
               2'b10: ctrl.aluOp = aluRor;
               default: ctrl.aluOp = aluSrl;
            endcase
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrt = 1'b1;
            ctrl.isSet  = 1'b1;
            ctrl.dstSel = dstRRd;
            ctrl.invB   = (instr.iForm.opcode != opSco); // rs minus rt for compares
            ctrl.cin    = (instr.iForm.opcode != opSco);
            case (instr.iForm.opcode)
               opSeq:   ctrl.condSel = condZero;
               opSlt:   ctrl.condSel = condSign;
               opSle:   ctrl.condSel = condSignOrZero;
               default: ctrl.condSel = condCarry;   // carry out of rs plus rt
            endcase
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.isBranch = 1'b1;
            ctrl.bSrc     = bZero;               // alu passes rs through
            case (instr.iForm.opcode)
               opBeqz:  ctrl.condSel = condZero;
               opBnez:  ctrl.condSel = condNotZero;
               opBltz:  ctrl.condSel = condSign;
               default: ctrl.condSel = condNotSign;
            endcase
         end
         opLbi: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wbImm8;
            ctrl.dstSel = dstRs;
         end
         opSlbi: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSel  = wbSlbi;
            ctrl.dstSel = dstRs;
         end
         opJ: begin
            ctrl.jumpDisp = 1'b1;
         end
         opJr: begin
            ctrl.jumpReg = 1'b1;
            ctrl.bSrc    = bImm8;                // target formed by alu
         end
         opJal, opJalr: begin
            ctrl.regWrt   = 1'b1;
            ctrl.wbSel    = wbLink;              // r7 gets pc plus 2
            ctrl.dstSel   = dstR7;
            ctrl.jumpDisp = (instr.iForm.opcode == opJal);
            ctrl.jumpReg  = (instr.iForm.opcode == opJalr);
            ctrl.bSrc     = bImm8;
         end
         default: begin
            ctrl.err = 1'b1;                     // unknown opcode
         end
      endcase
   end

endmodule

// ==== source/regFile.sv ====
////////////////////////////////////////
// WISC register file
////////////////////////////////////////
`timescale 1ns/1ps

module regFile (
   input  logic                          clk,
   input  logic                          reset,
   input  wiscPkg::regAddrT              rdAddrA,
   input  wiscPkg::regAddrT              rdAddrB,
   output logic [wiscPkg::dataWidth-1:0] rdDataA,
   output logic [wiscPkg::dataWidth-1:0] rdDataB,
   input  logic                          wrEn,
   input  wiscPkg::regAddrT              wrAddr,
   input  logic [wiscPkg::dataWidth-1:0] wrData
);
   import wiscPkg::*;

   logic [dataWidth-1:0] regs [regCount];

   // async read, old value seen during a same edge write
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;                       // all registers start at zero
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

endmodule

// ==== source/wiscCore.sv ====
////////////////////////////////////////
// WISC single issue core
////////////////////////////////////////
`timescale 1ns/1ps

module wiscCore (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          inValid,
   output logic                          inReady,
   input  wiscPkg::instrT                inInstr,
   input  logic [wiscPkg::dataWidth-1:0] inPc,
   output logic                          outValid,
   input  logic                          outReady,
   output wiscPkg::resultT               outResult
);
   import wiscPkg::*;

   ctrlT                 ctrl;
   logic [dataWidth-1:0] rsData, rtData;
   logic [dataWidth-1:0] aluOut;
   logic                 condTrue;
   logic                 wbEn;
   regAddrT              wbReg;
   logic [dataWidth-1:0] wbData, nextPc;
   logic                 accept;

   assign inReady = !outValid || outReady;       // slot free or draining this edge
   assign accept  = inValid && inReady;

   controlUnit uDecode (
      .instr (inInstr),
      .ctrl  (ctrl)
   );

   regFile uRegs (
      .clk     (clk),
      .reset   (reset),
      .rdAddrA (inInstr.rForm.rs),
      .rdAddrB (inInstr.rForm.rt),
      .rdDataA (rsData),
      .rdDataB (rtData),
      .wrEn    (accept && wbEn),                 // only on an accepted instruction
      .wrAddr  (wbReg),
      .wrData  (wbData)
   );

   aluExecute uExec (
      .ctrl     (ctrl),
      .instr    (inInstr),
      .rsData   (rsData),
      .rtData   (rtData),
      .aluOut   (aluOut),
      .condTrue (condTrue)
   );

   writebackSelect uResult (
      .ctrl     (ctrl),
      .instr    (inInstr),
      .pc       (inPc),
      .rsData   (rsData),
      .aluOut   (aluOut),
      .condTrue (condTrue),
      .wrEn     (wbEn),
      .wrReg    (wbReg),
      .wrData   (wbData),
      .nextPc   (nextPc)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         outValid  <= 1'b0;
         outResult <= '0;
      end else begin
         if (inReady) begin
            outValid <= inValid;                 // refill or empty the slot
         end
         if (accept) begin
            outResult.pc     <= inPc;
            outResult.nextPc <= nextPc;
            outResult.wrEn   <= wbEn;
            outResult.wrReg  <= wbReg;
            outResult.wrData <= wbData;
            outResult.halt   <= ctrl.halt;
            outResult.err    <= ctrl.err;
         end
      end
   end

endmodule

// ==== source/wiscPkg.sv ====
////////////////////////////////////////
// WISC core shared types
////////////////////////////////////////
package wiscPkg;

   localparam int dataWidth = 16;                // data and instruction width
   localparam int regCount  = 8;                 // architectural registers

   typedef logic [2:0] regAddrT;

   typedef enum logic [4:0] {
      opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
      opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
      opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
      opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
      opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
      opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
      opLbi   = 5'b11000, opBtr   = 5'b11001, opShiftR = 5'b11010, opAluR = 5'b11011,
      opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
   } opcodeT;

   typedef struct packed {opcodeT opcode; regAddrT rs; regAddrT rd; logic [4:0] imm5;} iFormT;
   typedef struct packed {
      opcodeT     opcode;
      regAddrT    rs;
      regAddrT    rt;
      regAddrT    rd;
      logic [1:0] func;                          // selects op within alu and shift groups
   } rFormT;
   typedef struct packed {opcodeT opcode; regAddrT rs; logic [7:0] imm8;} i2FormT;
   typedef struct packed {opcodeT opcode; logic [10:0] disp11;} jFormT;

   // same 16 bits seen through each instruction format
   typedef union packed {
      iFormT  iForm;
      rFormT  rForm;
      i2FormT i2Form;
      jFormT  jForm;
   } instrT;

   typedef enum logic [1:0] {bReg, bImm5, bImm8, bZero} bSrcT;
   typedef enum logic [1:0] {wbLink, wbAlu, wbImm8, wbSlbi} wbSelT;
   typedef enum logic [1:0] {dstIRd, dstRRd, dstRs, dstR7} dstSelT;
   typedef enum logic [2:0] {aluAdd, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl, aluBtr} aluOpT;
   typedef enum logic [2:0] {
      condNone, condZero, condNotZero, condSign, condNotSign, condSignOrZero, condCarry
   } condT;

   typedef struct packed {
      aluOpT  aluOp;
      logic   invA;                              // invert operand a before adder
      logic   invB;                              // invert operand b before adder
      logic   cin;
      bSrcT   bSrc;
      logic   zeroExt;                           // zero extend immediate instead of sign
      condT   condSel;
      logic   isSet;                             // write condTrue as 0 or 1
      logic   isBranch;
      logic   jumpDisp;                          // pc relative jump by disp11
      logic   jumpReg;                           // jump to rs plus imm8
      logic   regWrt;
      wbSelT  wbSel;
      dstSelT dstSel;
      logic   halt;
      logic   err;
   } ctrlT;

   typedef struct packed {
      logic [dataWidth-1:0] pc;
      logic [dataWidth-1:0] nextPc;
      logic                 wrEn;
      regAddrT              wrReg;
      logic [dataWidth-1:0] wrData;
      logic                 halt;
      logic                 err;
   } resultT;

endpackage

// ==== source/writebackSelect.sv ====
////////////////////////////////////////
// WISC writeback and next pc
////////////////////////////////////////
`timescale 1ns/1ps

module writebackSelect (
   input  wiscPkg::ctrlT                 ctrl,
   input  wiscPkg::instrT                instr,
   input  logic [wiscPkg::dataWidth-1:0] pc,
   input  logic [wiscPkg::dataWidth-1:0] rsData,
   input  logic [wiscPkg::dataWidth-1:0] aluOut,
   input  logic                          condTrue,
   output logic                          wrEn,
   output wiscPkg::regAddrT              wrReg,
   output logic [wiscPkg::dataWidth-1:0] wrData,
   output logic [wiscPkg::dataWidth-1:0] nextPc
);
   import wiscPkg::*;

   logic [dataWidth-1:0] pcInc, imm8Ext, dispExt;

   assign pcInc   = pc + dataWidth'(2);
   assign imm8Ext = {{(dataWidth-8){instr.i2Form.imm8[7]}}, instr.i2Form.imm8};
   assign dispExt = {{(dataWidth-11){instr.jForm.disp11[10]}}, instr.jForm.disp11};

   assign wrEn = ctrl.regWrt && !ctrl.err;       // memory ops never write

   always_comb begin
      case (ctrl.wbSel)
         wbLink: wrData = pcInc;                 // jal and jalr link value
         wbAlu:  wrData = ctrl.isSet ? {{(dataWidth-1){1'b0}}, condTrue} : aluOut;
         wbImm8: wrData = imm8Ext;               // lbi
         default: wrData = {rsData[dataWidth-9:0], instr.i2Form.imm8}; // slbi
      endcase
   end

   always_comb begin
      case (ctrl.dstSel)
         dstIRd:  wrReg = instr.iForm.rd;
         dstRRd:  wrReg = instr.rForm.rd;
         dstRs:   wrReg = instr.i2Form.rs;
         default: wrReg = 3'd7;
      endcase
   end

   always_comb begin
      if (ctrl.jumpReg) begin
         nextPc = aluOut;                        // rs plus imm8 from the alu
      end else if (ctrl.jumpDisp) begin
         nextPc = pcInc + dispExt;
      end else if (ctrl.isBranch && condTrue) begin
         nextPc = pcInc + imm8Ext;               // taken branch
      end else begin
         nextPc = pcInc;
      end
   end

endmodule

// ==== testbench/wiscCore_chk.sv ====
////////////////////////////////////////
// WISC core handshake checks
////////////////////////////////////////
`timescale 1ns/1ps

module wiscCore_chk (
   input logic            clk,
   input logic            reset,
   input logic            inValid,
   input logic            inReady,
   input logic            outValid,
   input logic            outReady,
   input wiscPkg::resultT outResult
);

   // result slot empty after every reset edge
   assert property (@(posedge clk) reset |=> !outValid)
      else $error("outValid high in the cycle after reset");

   assert property (@(posedge clk) disable iff (reset)
                    outValid && !outReady |=> outValid && $stable(outResult))
      else $error("outResult changed while the consumer stalled");   // held under back-pressure

   // accepted instruction shows up after exactly one edge
   assert property (@(posedge clk) disable iff (reset) inValid && inReady |=> outValid)
      else $error("accepted instruction gave no result in the next cycle");

endmodule

bind wiscCore wiscCore_chk chk_i (
   .clk       (clk),
   .reset     (reset),
   .inValid   (inValid),
   .inReady   (inReady),
   .outValid  (outValid),
   .outReady  (outReady),
   .outResult (outResult)
);

// ==== testbench/wiscCore_tb.sv ====
////////////////////////////////////////
// WISC core testbench
////////////////////////////////////////
`timescale 1ns/1ps

module wiscCore_tb;
   import wiscPkg::*;

   logic        clk;
   logic        reset;
   logic        inValid;
   logic        inReady;
   instrT       inInstr;
   logic [15:0] inPc;
   logic        outValid;
   logic        outReady;
   resultT      outResult;

   integer      seed = 32'h7df7bc9c;
   logic [15:0] model [8];                       // reference copy of the registers
   resultT      expQ [$];                        // expected results in issue order
   logic [15:0] pcNow;
   int          errors;
   int          checks;
   int          received;

   wiscCore dut_i (
      .clk       (clk),
      .reset     (reset),
      .inValid   (inValid),
      .inReady   (inReady),
      .inInstr   (inInstr),
      .inPc      (inPc),
      .outValid  (outValid),
      .outReady  (outReady),
      .outResult (outResult)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                     // 4 ns period
   end

   function automatic logic [15:0] rnd16();
      logic [31:0] v;
      v = $random(seed);
      return v[15:0];
   endfunction

   function automatic int randBelow(input int n);
      int v;
      v = $random(seed) & 32'h7fffffff;
      return v % n;
   endfunction

   // instruction encoders, one per format
   function automatic instrT iOp(input opcodeT op, input regAddrT rs, input regAddrT rd,
                                 input logic [4:0] imm5);
      return instrT'({op, rs, rd, imm5});
   endfunction

   function automatic instrT rOp(input opcodeT op, input regAddrT rs, input regAddrT rt,
                                 input regAddrT rd, input logic [1:0] func);
      return instrT'({op, rs, rt, rd, func});
   endfunction

   function automatic instrT i2Op(input opcodeT op, input regAddrT rs, input logic [7:0] imm8);
      return instrT'({op, rs, imm8});
   endfunction

   function automatic instrT jOp(input opcodeT op, input logic [10:0] disp);
      return instrT'({op, disp});
   endfunction

   function automatic logic [15:0] rotl(input logic [15:0] x, input logic [3:0] n);
      return (x << n) | (x >> (5'd16 - {1'b0, n}));
   endfunction

   function automatic logic [15:0] rotr(input logic [15:0] x, input logic [3:0] n);
      return (x >> n) | (x << (5'd16 - {1'b0, n}));
   endfunction

   function automatic logic [15:0] bitRev(input logic [15:0] x);
      logic [15:0] r;
      for (int i = 0; i < 16; i++) begin
         r[i] = x[15-i];
      end
      return r;
   endfunction

   function automatic logic branchTaken(input opcodeT op, input logic [15:0] rs);
      case (op)
         opBeqz:  return rs == 16'd0;
         opBnez:  return rs != 16'd0;
         opBltz:  return rs[15];                 // negative
         default: return !rs[15];
      endcase
   endfunction

   // ISA reference model, updates its own registers on a write
   task automatic predict(input instrT ins, input logic [15:0] pc, output resultT want);
      logic [15:0] rs;
      logic [15:0] rt;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [15:0] s8;
      logic [15:0] disp;
      logic [15:0] link;
      logic [15:0] val;
      logic [16:0] wide;
      logic        wr;
      regAddrT     dst;
      rs   = model[ins.rForm.rs];
      rt   = model[ins.rForm.rt];
      s5   = {{11{ins.iForm.imm5[4]}}, ins.iForm.imm5};
      z5   = {11'b0, ins.iForm.imm5};
      s8   = {{8{ins.i2Form.imm8[7]}}, ins.i2Form.imm8};
      disp = {{5{ins.jForm.disp11[10]}}, ins.jForm.disp11};
      link = pc + 16'd2;
      wide = {1'b0, rs} + {1'b0, rt};            // carry out for sco
      want = '0;
      want.pc     = pc;
      want.nextPc = link;
      wr  = 1'b1;                                // cleared by non writers
      val = '0;
      case (ins.iForm.opcode)
         opBtr, opAluR, opShiftR, opSeq, opSlt, opSle, opSco: dst = ins.rForm.rd;
         opLbi, opSlbi: dst = ins.i2Form.rs;
         opJal, opJalr: dst = 3'd7;
         default:       dst = ins.iForm.rd;
      endcase
      case (ins.iForm.opcode)
         opAddi:  val = rs + s5;
         opSubi:  val = s5 - rs;
         opXori:  val = rs ^ z5;
         opAndni: val = rs & ~z5;
         opRoli:  val = rotl(rs, z5[3:0]);
         opSlli:  val = rs << z5[3:0];
         opRori:  val = rotr(rs, z5[3:0]);
         opSrli:  val = rs >> z5[3:0];
         opBtr:   val = bitRev(rs);
         opAluR: begin
            case (ins.rForm.func)
               2'b00:   val = rs + rt;
               2'b01:   val = rt - rs;
               2'b10:   val = rs ^ rt;
               default: val = rs & ~rt;
            endcase
         end
         opShiftR: begin
            case (ins.rForm.func)
               2'b00:   val = rotl(rs, rt[3:0]);
               2'b01:   val = rs << rt[3:0];
               2'b10:   val = rotr(rs, rt[3:0]);
               default: val = rs >> rt[3:0];
            endcase
         end
         opSeq:   val = {15'b0, rs == rt};
         opSlt:   val = {15'b0, $signed(rs) < $signed(rt)};
         opSle:   val = {15'b0, $signed(rs) <= $signed(rt)};
         opSco:   val = {15'b0, wide[16]};
         opLbi:   val = s8;
         opSlbi:  val = {rs[7:0], ins.i2Form.imm8};
         opBeqz, opBnez, opBltz, opBgez: begin
            wr = 1'b0;
            if (branchTaken(ins.iForm.opcode, rs)) begin
               want.nextPc = link + s8;
            end
         end
         opJ: begin
            wr = 1'b0;
            want.nextPc = link + disp;
         end
         opJr: begin
            wr = 1'b0;
            want.nextPc = rs + s8;
         end
         opJal: begin
            val = link;
            want.nextPc = link + disp;
         end
         opJalr: begin
            val = link;                          // rs read before r7 changes
            want.nextPc = rs + s8;
         end
         opHalt: begin
            wr = 1'b0;
            want.halt = 1'b1;
         end
         opSt, opLd, opStu: begin
            wr = 1'b0;
            want.err = 1'b1;                     // no data memory
         end
         default: wr = 1'b0;                     // nop, siic, rti
      endcase
      want.wrEn = wr;
      if (wr) begin
         want.wrReg  = dst;
         want.wrData = val;
         model[dst]  = val;
      end
   endtask

   task automatic reportMismatch(input string field, input logic [15:0] e, input logic [15:0] g,
                                 input logic [15:0] pc);
      errors++;
      $display("MISMATCH at %0t ns: %s for pc %h expected %h got %h", $time, field, pc, e, g);
   endtask

   task automatic compareResult(input resultT want, input resultT got);
      checks++;
      if (got.pc !== want.pc) reportMismatch("pc", want.pc, got.pc, want.pc);
      if (got.nextPc !== want.nextPc) reportMismatch("nextPc", want.nextPc, got.nextPc, want.pc);
      if (got.wrEn !== want.wrEn) reportMismatch("wrEn", 16'(want.wrEn), 16'(got.wrEn), want.pc);
      if (got.halt !== want.halt) reportMismatch("halt", 16'(want.halt), 16'(got.halt), want.pc);
      if (got.err !== want.err) reportMismatch("err", 16'(want.err), 16'(got.err), want.pc);
      // destination and data only matter when a write happens
      if (want.wrEn && got.wrReg !== want.wrReg) begin
         reportMismatch("wrReg", 16'(want.wrReg), 16'(got.wrReg), want.pc);
      end
      if (want.wrEn && got.wrData !== want.wrData) begin
         reportMismatch("wrData", want.wrData, got.wrData, want.pc);
      end
   endtask

   // called just after a falling edge, returns at a falling edge
   task automatic sendInstr(input instrT ins);
      resultT want;
      int     waited;
      predict(ins, pcNow, want);
      expQ.push_back(want);
      inValid = 1'b1;
      inInstr = ins;
      inPc    = pcNow;
      pcNow   = pcNow + 16'd2;
      waited  = 0;
      #1;
      while (!inReady && waited < 50) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (!inReady) begin
         errors++;
         $display("timeout: inReady stayed low for 50 cycles at pc %h", inPc);
      end else begin
         @(posedge clk);                         // accepted here
      end
      @(negedge clk);
      inValid = 1'b0;
   endtask

   task automatic recvResult(input int maxStall);
      resultT got;
      int     waited;
      outReady = 1'b0;
      repeat (randBelow(maxStall + 1)) @(negedge clk);   // back-pressure
      outReady = 1'b1;
      waited = 0;
      #1;
      while (!outValid && waited < 50) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (!outValid) begin
         errors++;
         $display("timeout: no result within 50 cycles, %0d still expected", expQ.size());
         @(negedge clk);
      end else begin
         got = outResult;                        // stable mid cycle
         @(posedge clk);
         @(negedge clk);
         received++;
         if (expQ.size() == 0) begin
            errors++;
            $display("result for pc %h arrived with nothing outstanding", got.pc);
         end else begin
            compareResult(expQ.pop_front(), got);
         end
      end
   endtask

   task automatic issue(input instrT ins);
      sendInstr(ins);
      recvResult(0);
   endtask

   task automatic loadConst(input regAddrT r, input logic [15:0] v);
      issue(i2Op(opLbi, r, v[15:8]));
      issue(i2Op(opSlbi, r, v[7:0]));            // shift in the low byte
   endtask

   task automatic finishTest(input string name, input int errBefore);
      if (outValid || expQ.size() != 0) begin
         errors++;
         $display("%s: a result was left over at the end of the test", name);
      end
      $display("test %s done, %0d errors", name, errors - errBefore);
   endtask

   task automatic immediateOps();
      opcodeT      ops [8];
      logic [15:0] r;
      int          e0;
      ops = '{opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli};
      e0  = errors;
      for (int i = 0; i < 8; i++) begin
         r = rnd16();
         issue(i2Op(opLbi, regAddrT'(i), r[7:0]));
      end
      for (int rep = 0; rep < 3; rep++) begin
         for (int k = 0; k < 8; k++) begin
            r = rnd16();
            issue(iOp(ops[k], r[2:0], r[5:3], r[10:6]));
         end
      end
      finishTest("immediate ops", e0);
   endtask

   task automatic registerOps();
      logic [15:0] r;
      int          e0;
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         loadConst(regAddrT'(i), rnd16());       // full width operands
      end
      for (int rep = 0; rep < 2; rep++) begin
         for (int f = 0; f < 4; f++) begin
            r = rnd16();
            issue(rOp(opAluR, r[2:0], r[5:3], r[8:6], 2'(f)));
            r = rnd16();
            issue(rOp(opShiftR, r[2:0], r[5:3], r[8:6], 2'(f)));
         end
         r = rnd16();
         issue(rOp(opBtr, r[2:0], r[5:3], r[8:6], 2'b00));
      end
      finishTest("register ops", e0);
   endtask

   task automatic setOps();
      opcodeT      ops [4];
      logic [15:0] va [7];
      logic [15:0] vb [7];
      logic [15:0] r;
      regAddrT     ra;
      regAddrT     rb;
      int          e0;
      ops = '{opSeq, opSlt, opSle, opSco};
      // equal, less than both ways, carry out, signed extremes, minus one and one
      va  = '{16'd5, 16'hfffd, 16'd7, 16'hf000, 16'h8000, 16'h7fff, 16'hffff};
      vb  = '{16'd5, 16'd7, 16'hfffd, 16'h2000, 16'h7fff, 16'h8000, 16'h0001};
      e0  = errors;
      for (int k = 0; k < 4; k++) begin
         for (int p = 0; p < 7; p++) begin
            r  = rnd16();
            ra = r[5:3];
            rb = ra + 3'd1;                      // distinct operand registers
            loadConst(ra, va[p]);                // pair reloaded before every compare
            loadConst(rb, vb[p]);
            issue(rOp(ops[k], ra, rb, r[2:0], 2'b00));
         end
      end
      finishTest("set ops", e0);
   endtask

   task automatic controlFlow();
      opcodeT      ops [4];
      logic [15:0] r;
      int          e0;
      ops = '{opBeqz, opBnez, opBltz, opBgez};
      e0  = errors;
      r = rnd16();
      pcNow = {r[15:1], 1'b0};
      loadConst(3'd1, 16'h0000);
      loadConst(3'd2, 16'hff80);
      loadConst(3'd3, 16'h0040);
      for (int k = 0; k < 4; k++) begin
         for (int s = 1; s < 4; s++) begin
            r = rnd16();
            issue(i2Op(ops[k], regAddrT'(s), r[7:0]));   // zero, negative, positive
         end
      end
      r = rnd16();
      issue(jOp(opJ, r[10:0]));
      issue(i2Op(opJr, 3'd3, r[15:8]));
      r = rnd16();
      issue(jOp(opJal, r[10:0]));
      issue(iOp(opAddi, 3'd7, 3'd6, 5'd0));      // read back link
      issue(i2Op(opJalr, 3'd2, r[15:8]));
      issue(iOp(opAddi, 3'd7, 3'd6, 5'd0));
      loadConst(3'd4, 16'hbeef);
      issue(iOp(opAddi, 3'd4, 3'd5, 5'd0));
      finishTest("control flow", e0);
   endtask

   function automatic instrT randomInstr();
      logic [15:0] r;
      r = rnd16();
      case (randBelow(5))
         0:       return i2Op(opLbi, r[2:0], r[15:8]);
         1:       return iOp(opAddi, r[2:0], r[5:3], r[10:6]);
         2:       return rOp(opAluR, r[2:0], r[5:3], r[8:6], r[10:9]);
         3:       return i2Op(opSlbi, r[2:0], r[15:8]);
         default: return iOp(opRoli, r[2:0], r[5:3], r[10:6]);
      endcase
   endfunction

   task automatic streamWithStalls();
      int e0;
      e0 = errors;
      fork
         for (int i = 0; i < 40; i++) sendInstr(randomInstr());
         for (int i = 0; i < 40; i++) recvResult(3);
      join
      for (int i = 0; i < 8; i++) begin
         issue(iOp(opAddi, regAddrT'(i), regAddrT'(i), 5'd0));   // final register contents
      end
      finishTest("back-pressure", e0);
   endtask

   task automatic specialOpcodes();
      opcodeT      ops [7];
      logic [15:0] r;
      int          e0;
      ops = '{opHalt, opNop, opLd, opSt, opStu, opSiic, opRti};
      e0  = errors;
      for (int k = 0; k < 7; k++) begin
         r = rnd16();
         issue(iOp(ops[k], r[2:0], r[5:3], r[10:6]));
      end
      finishTest("special opcodes", e0);
   endtask

   initial begin
      reset    = 1'b1;
      inValid  = 1'b0;
      inInstr  = '0;
      inPc     = '0;
      outReady = 1'b1;
      pcNow    = 16'h0100;
      errors   = 0;
      checks   = 0;
      received = 0;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (outValid !== 1'b0 || inReady !== 1'b1) begin
         errors++;
         $display("core not idle after reset");
      end
      immediateOps();
      registerOps();
      setOps();
      controlFlow();
      streamWithStalls();
      specialOpcodes();
      $display("tests 6, checks %0d, results %0d, errors %0d", checks, received, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== wiscCore.f ====
source/wiscPkg.sv
source/controlUnit.sv
source/aluExecute.sv
source/regFile.sv
source/writebackSelect.sv
source/wiscCore.sv
testbench/wiscCore_chk.sv
testbench/wiscCore_tb.sv
